//--- sources.f
+incdir+verification
design/stageOnePkg.sv
design/instrDecoder.sv
design/operandFetch.sv
design/stageSequencer.sv
design/stageOneCtrl.sv
verification/stageOneCtrlTb.sv

//--- Bender.yml
package:
  name: stage_one_ctrl

sources:
  - design/stageOnePkg.sv
  - design/instrDecoder.sv
  - design/operandFetch.sv
  - design/stageSequencer.sv
  - design/stageOneCtrl.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/stageOneCtrlTb.sv

//--- verification/stageOneTasks.svh
////////////////////////////////////////////////////////////
// Per-cycle checks
////////////////////////////////////////////////////////////

task automatic checkCycle(input ctrlWord_t exp, input logic [ShiftWidth-1:0] shiftExp,
		input logic inAckExp, input logic outReqExp);
	assert (ctrl === exp)
		else abortRun($sformatf("Fail ctrl: got %h, expected %h", ctrl, exp));
	assert (shiftAmount === shiftExp)
		else abortRun($sformatf("Fail shiftAmount: got %h, expected %h", shiftAmount, shiftExp));
	assert (instrAck === 1'b0)
		else abortRun("instrAck is high while no instruction is being offered");
	assert (inAck === inAckExp)
		else abortRun($sformatf("Fail inAck: got %h, expected %h", inAck, inAckExp));
	assert (outReq === outReqExp)
		else abortRun($sformatf("Fail outReq: got %h, expected %h", outReq, outReqExp));
endtask

task automatic expectCycles(input ctrlWord_t exp, input int n,
		input logic [ShiftWidth-1:0] shiftExp, input logic inAckExp, input logic outReqExp);
	repeat (n) begin
		@(negedge clk);
		checkCycle(exp, shiftExp, inAckExp, outReqExp);
	end
endtask

// Stage 0 side of the instruction handshake, ends just before the route starts
task automatic sendInstr(input logic [InstrWidth-1:0] word, input logic hit);
	int waited;
	waited = 0;
	@(posedge clk);
	#DriveDelay;
	instr    = word;
	instrReq = 1'b1;
	cacheHit = hit;
	irData   = InstrWidth'($random(seed));
	do begin
		@(negedge clk);
		waited++;
		assert (ctrl === CtrlNop)
			else abortRun($sformatf("Fail ctrl: got %h, expected %h", ctrl, CtrlNop));
	end while (!instrAck && waited < 4);
	assert (instrAck === 1'b1) else abortRun("instrAck did not rise after instrReq");
	@(posedge clk);
	#DriveDelay;
	instrReq = 1'b0;
	instr    = InstrWidth'($random(seed)); // Latched copy must not follow
	@(negedge clk);
	assert (instrAck === 1'b1) else abortRun("instrAck fell before instrReq was released");
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic aluRoute(input opcode_t op, input aluOp_t expOp, input addrMode_t m,
		input logic hit);
	ctrlWord_t indW;
	ctrlWord_t fetchW;
	ctrlWord_t execW;
	int        lat;
	lat = hit ? HitCycles : MissCycles;
	indW = CtrlNop;
	indW.memRead = 1'b1;
	fetchW = indW;
	fetchW.addrFromMdr = (m == Ind);
	execW = CtrlNop;
	execW.aluOp    = expOp;
	execW.accWrite = 1'b1;
	execW.immSel   = (m == Imm);
	sendInstr({op, m}, hit);
	if (m == Ind) begin
		expectCycles(indW, lat, '0, 1'b0, 1'b0); // Pointer read
	end
	if (m != Imm) begin
		expectCycles(fetchW, lat, '0, 1'b0, 1'b0);
	end
	expectCycles(execW, 1, '0, 1'b0, 1'b0);
	expectCycles(CtrlNop, 1, '0, 1'b0, 1'b0);
endtask

task automatic storeRoute(input addrMode_t m, input logic hit);
	ctrlWord_t indW;
	ctrlWord_t storeW;
	int        lat;
	lat = hit ? HitCycles : MissCycles;
	indW = CtrlNop;
	indW.memRead = 1'b1;
	storeW = CtrlNop;
	storeW.memWrite    = 1'b1;
	storeW.addrFromMdr = (m == Ind);
	sendInstr({Stor, m}, hit);
	if (m == Ind) begin
		expectCycles(indW, lat, '0, 1'b0, 1'b0);
	end
	expectCycles(storeW, lat, '0, 1'b0, 1'b0);
	expectCycles(CtrlNop, 1, '0, 1'b0, 1'b0);
endtask

task automatic shiftForm(input addrMode_t m, input aluOp_t expOp);
	ctrlWord_t execW;
	execW = CtrlNop;
	execW.aluOp    = expOp;
	execW.accWrite = 1'b1;
	sendInstr({Shft, m}, 1'b1);
	expectCycles(execW, 1, irData[ShiftWidth-1:0], 1'b0, 1'b0);
	expectCycles(CtrlNop, 1, '0, 1'b0, 1'b0);
endtask

// Input device answers after a delay and holds inReq for a while after inAck
task automatic inputHandshake(input int delay);
	ctrlWord_t takeW;
	takeW = CtrlNop;
	takeW.aluOp    = AluPass;
	takeW.accWrite = 1'b1;
	takeW.ioRead   = 1'b1;
	sendInstr({Input, Dir}, 1'b1);
	expectCycles(CtrlNop, delay, '0, 1'b0, 1'b0);
	@(posedge clk);
	#DriveDelay;
	inReq = 1'b1;
	expectCycles(CtrlNop, 1, '0, 1'b0, 1'b0);
	expectCycles(takeW, 1, '0, 1'b1, 1'b0);
	expectCycles(CtrlNop, delay, '0, 1'b1, 1'b0);
	@(posedge clk);
	#DriveDelay;
	inReq = 1'b0;
	expectCycles(CtrlNop, 1, '0, 1'b1, 1'b0);
	expectCycles(CtrlNop, 1, '0, 1'b0, 1'b0);
endtask

task automatic outputHandshake(input int delay);
	ctrlWord_t outW;
	outW = CtrlNop;
	outW.ioWrite = 1'b1;
	sendInstr({Output, Dir}, 1'b1);
	expectCycles(outW, delay, '0, 1'b0, 1'b1);
	@(posedge clk);
	#DriveDelay;
	outAck = 1'b1;
	expectCycles(outW, 1, '0, 1'b0, 1'b1);
	expectCycles(CtrlNop, delay, '0, 1'b0, 1'b0);
	@(posedge clk);
	#DriveDelay;
	outAck = 1'b0;
	expectCycles(CtrlNop, 2, '0, 1'b0, 1'b0);
endtask

// Next sendInstr only gets an ack if the controller is back in Idle
task automatic nopReturn(input logic [InstrWidth-1:0] word);
	sendInstr(word, 1'b1);
	expectCycles(CtrlNop, 2, '0, 1'b0, 1'b0);
endtask

//--- verification/stageOneCtrlTb.sv
`default_nettype none

module stageOneCtrlTb;
	import stageOnePkg::*;

	localparam int ClkPeriod  = 40;
	localparam int DriveDelay = 5; // Inputs change this long after the rising edge

	// Worst case per test in cycles, ALU indirect miss being the longest
	localparam int TestCycles   = 30 * 30 + 26 * 4 + 8 * 4 + 24 * 2 + 8 * 5 + 10;
	localparam int WatchdogTime = 2 * TestCycles * ClkPeriod;

	logic                   clk = 1'b0;
	logic                   rst;
	logic [InstrWidth-1:0]  instr;
	logic                   instrReq;
	logic                   instrAck;
	logic [InstrWidth-1:0]  irData;
	logic                   cacheHit;
	logic                   inReq;
	logic                   inAck;
	logic                   outReq;
	logic                   outAck;
	ctrlWord_t              ctrl;
	logic [ShiftWidth-1:0]  shiftAmount;

	integer seed = 32'h1159_60d6;

	opcode_t   aluOpcodes [5] = '{Add, Sub, Or, And, Load};
	aluOp_t    aluResults [5] = '{AluAdd, AluSub, AluOr, AluAnd, AluPass};
	addrMode_t aluModes   [3] = '{Imm, Dir, Ind};

	always #(ClkPeriod / 2) clk = ~clk;

	stageOneCtrl dut_i (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instrReq    (instrReq),
		.instrAck    (instrAck),
		.irData      (irData),
		.cacheHit    (cacheHit),
		.inReq       (inReq),
		.inAck       (inAck),
		.outReq      (outReq),
		.outAck      (outAck),
		.ctrl        (ctrl),
		.shiftAmount (shiftAmount)
	);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	`include "stageOneTasks.svh"

	initial begin
		#(WatchdogTime);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////
	// Test order
	////////////////////////////////////////////////////////////

	initial begin
		rst      = 1'b1;
		instr    = '0;
		instrReq = 1'b0;
		irData   = '0;
		cacheHit = 1'b0;
		inReq    = 1'b0;
		outAck   = 1'b0;
		repeat (4) @(posedge clk);
		#DriveDelay;
		rst = 1'b0;
		@(negedge clk);
		checkCycle(CtrlNop, '0, 1'b0, 1'b0); // Idle word after reset

		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 3; j++) begin
				aluRoute(aluOpcodes[i], aluResults[i], aluModes[j], 1'b1);
				aluRoute(aluOpcodes[i], aluResults[i], aluModes[j], 1'b0);
			end
		end

		storeRoute(Dir, 1'b1);
		storeRoute(Dir, 1'b0);
		storeRoute(Ind, 1'b1);
		storeRoute(Ind, 1'b0);

		shiftForm(ShiftLeft0, AluShl0);
		shiftForm(ShiftLeft1, AluShl1);
		shiftForm(ShiftRight0, AluShr0);
		shiftForm(ShiftRight1, AluShr1);

		inputHandshake(3);
		outputHandshake(2);

		nopReturn({Nop, Dir});
		nopReturn(8'b00010_000);  // Unused opcode
		nopReturn(8'b11000_001);
		nopReturn({Stor, Imm});   // Illegal store mode
		nopReturn({Add, 3'b111}); // Illegal ALU mode

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/stageOneCtrl.sv
`default_nettype none

module stageOneCtrl (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [stageOnePkg::InstrWidth-1:0] instr,
	input  logic                               instrReq,
	output logic                               instrAck,
	input  logic [stageOnePkg::InstrWidth-1:0] irData,
	input  logic                               cacheHit,
	input  logic                               inReq,
	output logic                               inAck,
	output logic                               outReq,
	input  logic                               outAck,
	output stageOnePkg::ctrlWord_t             ctrl,
	output logic [stageOnePkg::ShiftWidth-1:0] shiftAmount
);
	import stageOnePkg::*;

	logic      instrLoad;
	route_t    route;
	aluOp_t    aluOp;
	addrMode_t mode;
	logic      memAccess;
	logic      fetchDone;

	instrDecoder decoder_i (
		.clk       (clk),
		.rst       (rst),
		.instrLoad (instrLoad),
		.instr     (instr),
		.route     (route),
		.aluOp     (aluOp),
		.mode      (mode)
	);

	operandFetch fetch_i (
		.clk       (clk),
		.rst       (rst),
		.memAccess (memAccess),
		.cacheHit  (cacheHit),
		.fetchDone (fetchDone)
	);

	stageSequencer sequencer_i (
		.clk         (clk),
		.rst         (rst),
		.instrReq    (instrReq),
		.instrLoad   (instrLoad),
		.instrAck    (instrAck),
		.route       (route),
		.aluOp       (aluOp),
		.mode        (mode),
		.memAccess   (memAccess),
		.fetchDone   (fetchDone),
		.inReq       (inReq),
		.inAck       (inAck),
		.outReq      (outReq),
		.outAck      (outAck),
		.irData      (irData),
		.ctrl        (ctrl),
		.shiftAmount (shiftAmount)
	);

endmodule

`default_nettype wire

//--- design/stageSequencer.sv
`default_nettype none

module stageSequencer (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               instrReq,
	output logic                               instrLoad,
	output logic                               instrAck,
	input  stageOnePkg::route_t                route,
	input  stageOnePkg::aluOp_t                aluOp,
	input  stageOnePkg::addrMode_t             mode,
	output logic                               memAccess,
	input  logic                               fetchDone,
	input  logic                               inReq,
	output logic                               inAck,
	output logic                               outReq,
	input  logic                               outAck,
	input  logic [stageOnePkg::InstrWidth-1:0] irData,
	output stageOnePkg::ctrlWord_t             ctrl,
	output logic [stageOnePkg::ShiftWidth-1:0] shiftAmount
);
	import stageOnePkg::*;

	stageState_t state;
	stageState_t nextState;
	stageState_t routeStart; // First state of the decoded route

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////////////////////////
	// Route entry and next state
	////////////////////////////////////////////////////////////

	always_comb begin
		routeStart = Idle;
		case (route)
			RouteAlu: begin
				if (mode == Imm) begin
					routeStart = Execute;
				end else if (mode == Ind) begin
					routeStart = IndFetch;
				end else begin
					routeStart = Fetch;
				end
			end
			RouteStore: begin
				if (mode == Ind) begin
					routeStart = IndFetch;
				end else begin
					routeStart = Store;
				end
			end
			RouteShift:  routeStart = Execute;
			RouteInput:  routeStart = InWait;
			RouteOutput: routeStart = OutDrive;
			default:     routeStart = Idle; // NOP finishes at once
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (instrReq) begin
					nextState = Accept;
				end
			end
			Accept: begin
				if (!instrReq) begin
					nextState = routeStart; // Stage 0 released its request
				end
			end
			IndFetch: begin
				if (fetchDone) begin
					if (route == RouteStore) begin
						nextState = Store;
					end else begin
						nextState = Fetch;
					end
				end
			end
			Fetch: begin
				if (fetchDone) begin
					nextState = Execute;
				end
			end
			Execute: nextState = Idle;
			Store: begin
				if (fetchDone) begin
					nextState = Idle;
				end
			end
			InWait: begin
				if (inReq) begin
					nextState = InTake;
				end
			end
			InTake: nextState = InRelease;
			InRelease: begin
				if (!inReq) begin
					nextState = Idle;
				end
			end
			OutDrive: begin
				if (outAck) begin
					nextState = OutRelease;
				end
			end
			OutRelease: begin
				if (!outAck) begin
					nextState = Idle;
				end
			end
			default: nextState = Idle;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Handshakes and control word
	////////////////////////////////////////////////////////////

	assign instrLoad = (state == Idle) && instrReq; // Latch on first sight
	assign instrAck  = (state == Accept);
	assign inAck     = (state == InTake) || (state == InRelease);
	assign outReq    = (state == OutDrive);
	assign memAccess = state inside {IndFetch, Fetch, Store};

	always_comb begin
		ctrl = CtrlNop;
		case (state)
			IndFetch: ctrl.memRead = 1'b1; // Fetch pointer word
			Fetch: begin
				ctrl.memRead     = 1'b1;
				ctrl.addrFromMdr = (mode == Ind);
			end
			Store: begin
				ctrl.memWrite    = 1'b1;
				ctrl.addrFromMdr = (mode == Ind);
			end
			Execute: begin
				ctrl.aluOp    = aluOp;
				ctrl.accWrite = 1'b1;
				// Shift mode bits overlap Imm, so check the route too
				ctrl.immSel   = (route == RouteAlu) && (mode == Imm);
			end
			InTake: begin
				ctrl.aluOp    = AluPass;
				ctrl.accWrite = 1'b1;
				ctrl.ioRead   = 1'b1;
			end
			OutDrive: ctrl.ioWrite = 1'b1;
			default:  ctrl = CtrlNop;
		endcase
	end

	always_comb begin
		shiftAmount = '0;
		if (state == Execute && route == RouteShift) begin
			shiftAmount = irData[ShiftWidth-1:0]; // Amount from data register
		end
	end

	// Stage 0 holds its request until it sees the ack
	reqHeld: assert property (@(posedge clk) disable iff (rst)
		instrReq && !instrAck |=> instrReq);

endmodule

`default_nettype wire

//--- design/operandFetch.sv
`default_nettype none

module operandFetch (
	input  logic clk,
	input  logic rst,
	input  logic memAccess,
	input  logic cacheHit,
	output logic fetchDone
);
	import stageOnePkg::*;

	logic                      busy;      // Past the first cycle of an access
	logic                      firstCycle;
	logic [WaitCountWidth-1:0] waitCount;
	logic [WaitCountWidth-1:0] lastCount; // Count value of the final cycle

	assign firstCycle = memAccess && !busy;

	// Latency picked once, from the hit seen in the first cycle
	always_ff @(posedge clk) begin
		if (firstCycle) begin
			if (cacheHit) begin
				lastCount <= WaitCountWidth'(HitCycles - 1);
			end else begin
				lastCount <= WaitCountWidth'(MissCycles - 1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			waitCount <= '0;
		end else if (memAccess && !fetchDone) begin
			busy      <= 1'b1;
			waitCount <= waitCount + 1'b1;
		end else begin
			busy      <= 1'b0; // Done or idle, next access starts fresh
			waitCount <= '0;
		end
	end

	assign fetchDone = memAccess && busy && (waitCount == lastCount);

	// The sequencer must stay in the access state until it completes
	accessHeld: assert property (@(posedge clk) disable iff (rst)
		memAccess && !fetchDone |=> memAccess);

endmodule

`default_nettype wire

//--- design/instrDecoder.sv
`default_nettype none

module instrDecoder (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              instrLoad,
	input  logic [stageOnePkg::InstrWidth-1:0] instr,
	output stageOnePkg::route_t               route,
	output stageOnePkg::aluOp_t               aluOp,
	output stageOnePkg::addrMode_t            mode
);
	import stageOnePkg::*;

	logic [InstrWidth-1:0] instrReg;
	opcode_t               opcode;
	logic                  aluMode;   // Dir, Ind or Imm
	logic                  storeMode; // Dir or Ind only
	logic                  shiftMode; // One of the four shift forms

	always_ff @(posedge clk) begin
		if (rst) begin
			instrReg <= {Nop, Dir}; // Decodes as a NOP
		end else if (instrLoad) begin
			instrReg <= instr;
		end
	end

	assign opcode = opcode_t'(instrReg[InstrWidth-1 -: OpcodeWidth]);
	assign mode   = instrReg[ModeWidth-1:0];

	assign aluMode   = mode inside {Dir, Ind, Imm};
	assign storeMode = mode inside {Dir, Ind};
	assign shiftMode = mode inside {ShiftLeft0, ShiftLeft1, ShiftRight0, ShiftRight1};

	////////////////////////////////////////////////////////////
	// Opcode classification
	////////////////////////////////////////////////////////////

	always_comb begin
		route = RouteNop;
		case (opcode)
			Add, Sub, Or, And, Load: begin
				if (aluMode) begin
					route = RouteAlu;
				end
			end
			Stor: begin
				if (storeMode) begin
					route = RouteStore;
				end
			end
			Shft: begin
				if (shiftMode) begin
					route = RouteShift;
				end
			end
			Input:   route = RouteInput;
			Output:  route = RouteOutput;
			default: route = RouteNop; // Dropped opcodes and NOP
		endcase
	end

	always_comb begin
		aluOp = AluPass; // LOAD and the non-ALU routes
		case (opcode)
			Add: aluOp = AluAdd;
			Sub: aluOp = AluSub;
			Or:  aluOp = AluOr;
			And: aluOp = AluAnd;
			Shft: begin
				case (mode)
					ShiftLeft0:  aluOp = AluShl0;
					ShiftLeft1:  aluOp = AluShl1;
					ShiftRight0: aluOp = AluShr0;
					ShiftRight1: aluOp = AluShr1;
					default:     aluOp = AluPass;
				endcase
			end
			default: aluOp = AluPass;
		endcase
	end

	// Stage 0 must hold a defined instruction while the latch strobe is up
	loadKnown: assert property (@(posedge clk) disable iff (rst)
		instrLoad |-> !$isunknown(instr));

endmodule

`default_nettype wire

//--- design/stageOnePkg.sv
`default_nettype none

package stageOnePkg;

	////////////////////////////////////////////////////////////
	// Field widths and cache timing
	////////////////////////////////////////////////////////////

	localparam int InstrWidth     = 8;
	localparam int OpcodeWidth    = 5;
	localparam int ModeWidth      = 3;
	localparam int ShiftWidth     = 3;
	localparam int WaitCountWidth = 4;

	localparam int HitCycles  = 2;  // Access length on a hit
	localparam int MissCycles = 11; // Access length on a miss

	////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////

	typedef enum logic [OpcodeWidth-1:0] {
		Add    = 5'b00000,
		Sub    = 5'b00001,
		Or     = 5'b00011,
		And    = 5'b00100,
		Shft   = 5'b00101,
		Load   = 5'b01010,
		Stor   = 5'b01011,
		Input  = 5'b01100,
		Output = 5'b01101,
		Nop    = 5'b01111
	} opcode_t;

	typedef logic [ModeWidth-1:0] addrMode_t;

	// Memory op addressing
	localparam addrMode_t Dir = 3'b000;
	localparam addrMode_t Ind = 3'b001;
	localparam addrMode_t Imm = 3'b010;

	// Same bits on SHFT select direction and fill
	localparam addrMode_t ShiftLeft0  = 3'b000;
	localparam addrMode_t ShiftLeft1  = 3'b001;
	localparam addrMode_t ShiftRight0 = 3'b010;
	localparam addrMode_t ShiftRight1 = 3'b011;

	////////////////////////////////////////////////////////////
	// Decode results and control word
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		RouteAlu,
		RouteStore,
		RouteShift,
		RouteInput,
		RouteOutput,
		RouteNop
	} route_t;

	typedef enum logic [3:0] {
		AluPass,
		AluAdd,
		AluSub,
		AluOr,
		AluAnd,
		AluShl0,
		AluShl1,
		AluShr0,
		AluShr1
	} aluOp_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic   accWrite;
		logic   memRead;
		logic   memWrite;
		logic   addrFromMdr; // Address taken from data register
		logic   immSel;      // Operand is the data field
		logic   ioRead;
		logic   ioWrite;
	} ctrlWord_t;

	localparam ctrlWord_t CtrlNop = '{
		aluOp:       AluPass,
		accWrite:    1'b0,
		memRead:     1'b0,
		memWrite:    1'b0,
		addrFromMdr: 1'b0,
		immSel:      1'b0,
		ioRead:      1'b0,
		ioWrite:     1'b0
	};

	typedef enum logic [3:0] {
		Idle,
		Accept,
		IndFetch,
		Fetch,
		Execute,
		Store,
		InWait,
		InTake,
		InRelease,
		OutDrive,
		OutRelease
	} stageState_t;

endpackage

`default_nettype wire
